// ==== flist.f ====
hw/dp_pkg.sv
hw/dp_coe_loader.sv
hw/dp_triple_pp_buffer.sv
hw/dp_madd.sv
hw/dp_top.sv
test/tb_dp_top.sv

// ==== hw/dp_coe_loader.sv ====
module dp_coe_loader
    import dp_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    // load stream
    input  logic     i_load_valid,
    input  coe_idx_t i_load_idx,
    input  coe_vec_t i_load_data,
    input  logic     i_load_last,
    // rotation pulse from the buffer
    input  logic     i_swap,
    // to the buffer load slot
    output buf_wr_t  o_wr,
    output logic     o_load_done
);

    logic       wr_we_q;     // write strobe, one cycle behind the stream
    bank_sel_t  wr_bank_q;
    word_addr_t wr_word_q;
    coe_vec_t   wr_data_q;
    logic       load_done_q;

    ////////////////////////////////////////
    // write register
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_we_q <= 1'b0;
        end else begin
            wr_we_q <= i_load_valid;
        end
    end

    // payload, no reset needed
    always_ff @(posedge i_clk) begin
        wr_bank_q <= i_load_idx[LOG_NUM_BANK-1:0];              // low bits pick the bank
        wr_word_q <= i_load_idx[COE_IDX_WIDTH-1:LOG_NUM_BANK];  // high bits pick the word
        wr_data_q <= i_load_data;
    end

    always_comb begin
        o_wr.we   = wr_we_q;
        o_wr.bank = wr_bank_q;
        o_wr.word = wr_word_q;
        o_wr.data = wr_data_q;
    end

    ////////////////////////////////////////
    // load completion
    ////////////////////////////////////////
    // set on the final write, held until the slots rotate
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            load_done_q <= 1'b0;
        end else if (i_load_valid && i_load_last) begin
            load_done_q <= 1'b1;
        end else if (i_swap) begin
            load_done_q <= 1'b0;    // new load slot is empty
        end
    end

    assign o_load_done = load_done_q;

endmodule

// ==== hw/dp_madd.sv ====
module dp_madd
    import dp_pkg::*;
#(
    parameter coe_t COE_MODULUS = 39'd549755813881  // 2^39 - 7
) (
    input  logic     i_clk,
    input  logic     i_rst,
    // control
    input  logic     i_madd_start,
    input  logic     i_swap,
    // drain slot read
    output coe_idx_t o_rd_idx,
    input  coe_vec_t i_rd_data,
    // external partial sums, same latency as the buffer
    input  coe_vec_t i_psum,
    // result
    output madd_wr_t o_wr,
    output logic     o_madd_done
);

    typedef logic [COE_WIDTH:0] coe_sum_t;  // one carry bit above a coefficient

    madd_state_t state_q;
    coe_idx_t    rd_idx_q;    // stage 0, address on the buffer
    logic        vld_d1_q;    // stage 1, data and psum arrive
    coe_idx_t    idx_d1_q;
    logic        wr_we_q;     // stage 2, result out
    coe_idx_t    wr_idx_q;
    coe_vec_t    wr_data_q;
    logic        done_q;
    logic        start_ok;
    logic        last_idx;
    coe_sum_t    sum [NUM_POLY];
    coe_vec_t    madd_res;

    assign start_ok = i_madd_start && !done_q;          // only once per rotation
    assign last_idx = (rd_idx_q == coe_idx_t'(NUM_COE - 1));

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q  <= IDLE;
            rd_idx_q <= '0;
            done_q   <= 1'b1;   // drain idle out of reset
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_ok) begin
                        state_q  <= WALK;
                        rd_idx_q <= '0;
                    end else if (i_swap) begin
                        done_q <= 1'b0;   // fresh drain slot waiting
                    end
                end
                WALK: begin
                    if (last_idx) begin
                        state_q <= FLUSH;
                    end else begin
                        rd_idx_q <= rd_idx_q + coe_idx_t'(1);
                    end
                end
                FLUSH: begin
                    // last write on the output this cycle
                    if (!vld_d1_q && wr_we_q) begin
                        state_q <= IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign o_rd_idx    = rd_idx_q;
    assign o_madd_done = done_q;

    ////////////////////////////////////////
    // index pipeline
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            vld_d1_q <= 1'b0;
            wr_we_q  <= 1'b0;
        end else begin
            vld_d1_q <= (state_q == WALK);   // address valid only while walking
            wr_we_q  <= vld_d1_q;
        end
    end

    always_ff @(posedge i_clk) begin
        idx_d1_q  <= rd_idx_q;
        wr_idx_q  <= idx_d1_q;
        wr_data_q <= madd_res;
    end

    ////////////////////////////////////////
    // modular add, per poly
    ////////////////////////////////////////
    always_comb begin
        for (int p = 0; p < NUM_POLY; p++) begin
            sum[p] = {1'b0, i_rd_data.poly[p]} + {1'b0, i_psum.poly[p]};
            // both inputs below the modulus, one subtract is enough
            if (sum[p] >= {1'b0, COE_MODULUS}) begin
                madd_res.poly[p] = coe_t'(sum[p] - {1'b0, COE_MODULUS});
            end else begin
                madd_res.poly[p] = coe_t'(sum[p]);
            end
        end
    end

    always_comb begin
        o_wr.we   = wr_we_q;
        o_wr.idx  = wr_idx_q;
        o_wr.data = wr_data_q;
    end

endmodule

// ==== hw/dp_pkg.sv ====
package dp_pkg;

    ////////////////////////////////////////
    // widths and counts
    ////////////////////////////////////////
    localparam int COE_WIDTH     = 39;  // one coefficient
    localparam int ADDR_WIDTH    = 4;   // log2 of words per bank
    localparam int LOG_NUM_BANK  = 3;   // bank select width
    localparam int NUM_BASE_BANK = 8;   // banks per poly
    localparam int NUM_POLY      = 3;   // polys per polyvec
    localparam int NUM_SLOT      = 3;   // load, hold, drain

    localparam int NUM_WORD      = 1 << ADDR_WIDTH;
    localparam int NUM_COE       = NUM_BASE_BANK * NUM_WORD; // 128 per poly
    localparam int COE_IDX_WIDTH = LOG_NUM_BANK + ADDR_WIDTH;

    ////////////////////////////////////////
    // plain vectors
    ////////////////////////////////////////
    typedef logic [COE_WIDTH-1:0]     coe_t;
    typedef logic [COE_IDX_WIDTH-1:0] coe_idx_t;   // {word, bank}
    typedef logic [LOG_NUM_BANK-1:0]  bank_sel_t;
    typedef logic [ADDR_WIDTH-1:0]    word_addr_t;
    typedef logic [1:0]               slot_t;      // 0..2 only

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////
    typedef struct packed {
        coe_t [NUM_POLY-1:0] poly;  // poly 0 sits in the low bits
    } coe_vec_t;

    typedef struct packed {
        logic       we;
        bank_sel_t  bank;
        word_addr_t word;
        coe_vec_t   data;
    } buf_wr_t;

    typedef struct packed {
        logic     we;
        coe_idx_t idx;
        coe_vec_t data;
    } madd_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        WALK,
        FLUSH
    } madd_state_t;

endpackage

// ==== hw/dp_top.sv ====
module dp_top
    import dp_pkg::*;
#(
    parameter coe_t COE_MODULUS = 39'd549755813881  // 2^39 - 7, any odd value works
) (
    input  logic     i_clk,
    input  logic     i_rst,
    // load stream into the load slot
    input  logic     i_load_valid,
    input  coe_idx_t i_load_idx,
    input  coe_vec_t i_load_data,
    input  logic     i_load_last,
    // multiply-add control
    input  logic     i_madd_start,
    output logic     o_madd_done,
    // partial-sum memory, one cycle read latency
    output coe_idx_t o_madd_rdaddr,
    input  coe_vec_t i_madd_data,
    // results
    output logic     o_madd_we,
    output coe_idx_t o_madd_wraddr,
    output coe_vec_t o_madd_data,
    // current load slot
    output slot_t    o_tpp_mode
);

    buf_wr_t  load_wr;
    logic     load_done;
    logic     madd_done;
    logic     swap;
    coe_idx_t madd_rd_idx;  // shared by the buffer and the psum memory
    coe_vec_t tpp_madd_data;
    madd_wr_t madd_wr;

    ////////////////////////////////////////
    // producer
    ////////////////////////////////////////
    dp_coe_loader u_loader (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_load_valid (i_load_valid),
        .i_load_idx   (i_load_idx),
        .i_load_data  (i_load_data),
        .i_load_last  (i_load_last),
        .i_swap       (swap),
        .o_wr         (load_wr),
        .o_load_done  (load_done)
    );

    ////////////////////////////////////////
    // triple ping-pong buffer
    ////////////////////////////////////////
    dp_triple_pp_buffer u_tri_pp (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_wr        (load_wr),
        .i_load_done (load_done),
        .i_madd_done (madd_done),
        .i_rd_idx    (madd_rd_idx),
        .o_rd_data   (tpp_madd_data),
        .o_swap      (swap),
        .o_tpp_mode  (o_tpp_mode)
    );

    ////////////////////////////////////////
    // consumer
    ////////////////////////////////////////
    dp_madd #(
        .COE_MODULUS (COE_MODULUS)
    ) u_madd (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_madd_start (i_madd_start),
        .i_swap       (swap),
        .o_rd_idx     (madd_rd_idx),
        .i_rd_data    (tpp_madd_data),
        .i_psum       (i_madd_data),
        .o_wr         (madd_wr),
        .o_madd_done  (madd_done)
    );

    assign o_madd_rdaddr = madd_rd_idx;
    assign o_madd_done   = madd_done;
    assign o_madd_we     = madd_wr.we;     // unpack the result bundle
    assign o_madd_wraddr = madd_wr.idx;
    assign o_madd_data   = madd_wr.data;

endmodule

// ==== hw/dp_triple_pp_buffer.sv ====
module dp_triple_pp_buffer
    import dp_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    // load side
    input  buf_wr_t  i_wr,
    input  logic     i_load_done,
    // multiply-add side
    input  logic     i_madd_done,
    input  coe_idx_t i_rd_idx,
    output coe_vec_t o_rd_data,
    // rotation
    output logic     o_swap,
    output slot_t    o_tpp_mode
);

    // three slots x eight banks x sixteen words
    coe_vec_t mem [NUM_SLOT][NUM_BASE_BANK][NUM_WORD];

    slot_t      tpp_mode_q;  // current load slot
    slot_t      drain_slot;
    logic       swap_q;
    logic       done_join;
    bank_sel_t  rd_bank;
    word_addr_t rd_word;
    coe_vec_t   rd_data_q;

    // step a slot number by one, modulo 3
    function automatic slot_t slot_inc(input slot_t s);
        slot_t n;
        if (s == slot_t'(NUM_SLOT - 1)) begin
            n = '0;
        end else begin
            n = s + slot_t'(1);
        end
        return n;
    endfunction

    ////////////////////////////////////////
    // slot roles
    ////////////////////////////////////////
    // load = mode, drain = mode+1, hold = mode+2 (all mod 3)
    // the hold slot is only parked data, nobody touches it
    assign drain_slot = slot_inc(tpp_mode_q);

    ////////////////////////////////////////
    // done join and rotation
    ////////////////////////////////////////
    // both sides finished, and not the cycle right after a swap
    // since the done levels only drop one edge later
    assign done_join = i_load_done && i_madd_done && !swap_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            swap_q     <= 1'b0;
            tpp_mode_q <= '0;
        end else begin
            swap_q <= done_join;
            if (done_join) begin
                tpp_mode_q <= slot_inc(tpp_mode_q);  // rotate all three roles
            end
        end
    end

    assign o_swap     = swap_q;
    assign o_tpp_mode = tpp_mode_q;

    ////////////////////////////////////////
    // banked storage
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_wr.we) begin
            mem[tpp_mode_q][i_wr.bank][i_wr.word] <= i_wr.data;  // load slot only
        end
    end

    // index split same as on the load side
    assign rd_bank = i_rd_idx[LOG_NUM_BANK-1:0];
    assign rd_word = i_rd_idx[COE_IDX_WIDTH-1:LOG_NUM_BANK];

    // registered read from the drain slot, one cycle latency
    always_ff @(posedge i_clk) begin
        rd_data_q <= mem[drain_slot][rd_bank][rd_word];
    end

    assign o_rd_data = rd_data_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# compile the dp_top testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_dp_top \
    -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build returned status $status"
    exit "$status"
fi

./obj_dir/Vtb_dp_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation returned status $status"
    exit "$status"
fi

exit 0

// ==== test/tb_dp_top.sv ====
module tb_dp_top
    import dp_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////
    // constants and signals
    ////////////////////////////////////////
    localparam int          PERIOD      = 100;                      // ns
    localparam logic [31:0] SEED        = 32'h6c63;
    localparam int          CYCLE_LIMIT = 4 * (4 * 131 + 4 * 130);  // runs and loads with 4x slack
    localparam coe_t        MODULUS     = 39'd549755813881;         // 2^39 - 7
    localparam coe_t        TOP_COE     = MODULUS - coe_t'(1);      // largest legal value

    logic        clk = 1'b0;
    logic        rst;
    logic        load_valid;
    coe_idx_t    load_idx;
    coe_vec_t    load_data;
    logic        load_last;
    logic        madd_start;
    logic        madd_done;
    coe_idx_t    madd_rdaddr;
    coe_vec_t    madd_data = '0;               // psum memory read data
    logic        madd_we;
    coe_idx_t    madd_wraddr;
    coe_vec_t    madd_out;
    slot_t       tpp_mode;

    coe_vec_t    psum_mem [NUM_COE];           // same partial sums for every run
    coe_vec_t    load_vec [NUM_SLOT][NUM_COE]; // scoreboard with one row per load
    coe_idx_t    psum_addr_q = '0;
    coe_idx_t    rdaddr_d1   = '0;             // read address one cycle back
    coe_idx_t    rdaddr_d2   = '0;             // and two cycles back
    logic [31:0] lfsr_state  = SEED;
    int          cycle_cnt   = 0;
    int          wr_total    = 0;              // all writes seen so far
    int          run_base    = 0;              // wr_total at run start
    logic        check_on    = 1'b0;           // data check enabled
    slot_t       check_slot  = '0;             // load the run should drain

    always #(PERIOD / 2) clk = ~clk;

    dp_top #(
        .COE_MODULUS (MODULUS)
    ) u_dp_top (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_load_valid  (load_valid),
        .i_load_idx    (load_idx),
        .i_load_data   (load_data),
        .i_load_last   (load_last),
        .i_madd_start  (madd_start),
        .o_madd_done   (madd_done),
        .o_madd_rdaddr (madd_rdaddr),
        .i_madd_data   (madd_data),
        .o_madd_we     (madd_we),
        .o_madd_wraddr (madd_wraddr),
        .o_madd_data   (madd_out),
        .o_tpp_mode    (tpp_mode)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32,22,2,1
    endfunction

    // 38 bits keep every value below the modulus
    function automatic coe_t rand_coe();
        coe_t v;
        v = '0;
        for (int b = 0; b < COE_WIDTH - 1; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[COE_WIDTH-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] expected_sum(input coe_t a, input coe_t b);
        return (64'(a) + 64'(b)) % 64'(MODULUS);
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp == act) else begin
            $display("FAIL %0t %s expected %0d got %0d", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%0t %s", $time, what);
            $display("Simulation failed");
            $fatal(1, "check failed");
        end
    endtask

    ////////////////////////////////////////
    // timeout, psum memory, output monitor
    ////////////////////////////////////////
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run went past %0d cycles, the DUT stopped making progress", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // one cycle read latency like the buffer
    always @(posedge clk) begin
        #1;
        madd_data   = psum_mem[psum_addr_q];
        psum_addr_q = madd_rdaddr;
    end

    always @(negedge clk) begin
        coe_idx_t k;
        if (!rst && madd_we) begin
            check_true(wr_total - run_base < NUM_COE, "more than 128 writes in one run");
            k = coe_idx_t'(wr_total - run_base);
            check_value("o_madd_wraddr", 64'(k), 64'(madd_wraddr));  // strictly in order
            check_value("o_madd_rdaddr", 64'(k), 64'(rdaddr_d2));    // read two cycles before
            if (check_on) begin
                for (int p = 0; p < NUM_POLY; p++) begin
                    check_value($sformatf("o_madd_data.poly[%0d] at %0d", p, k),
                                expected_sum(load_vec[check_slot][k].poly[p],
                                             psum_mem[k].poly[p]),
                                64'(madd_out.poly[p]));
                end
            end
            wr_total++;
        end
        rdaddr_d2 = rdaddr_d1;
        rdaddr_d1 = madd_rdaddr;
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_done(input logic level);
        while (madd_done != level) begin
            step();
        end
    endtask

    task automatic pulse_start();
        madd_start = 1'b1;
        step();
        madd_start = 1'b0;
    endtask

    // full polyvec in scattered index order with bank 7 pinned at the top value
    task automatic load_polyvec(input slot_t id);
        coe_idx_t idx;
        for (int k = 0; k < NUM_COE; k++) begin
            idx = coe_idx_t'((k * 37) % NUM_COE);
            for (int p = 0; p < NUM_POLY; p++) begin
                if (idx[LOG_NUM_BANK-1:0] == '1) begin
                    load_vec[id][idx].poly[p] = TOP_COE;  // forces a wrap
                end else begin
                    load_vec[id][idx].poly[p] = rand_coe();
                end
            end
            load_valid = 1'b1;
            load_idx   = idx;
            load_data  = load_vec[id][idx];
            load_last  = (k == NUM_COE - 1);
            step();
        end
        load_valid = 1'b0;
        load_last  = 1'b0;
    endtask

    task automatic run_madd(input logic on, input slot_t id, input logic extra_start);
        check_on   = on;
        check_slot = id;
        run_base   = wr_total;
        check_true(!madd_done, "multiply-add side not armed before start");
        pulse_start();
        if (extra_start) begin
            repeat (40) step();
            pulse_start();  // ignored in the middle of a run
        end
        wait_done(1'b1);
        check_true(wr_total - run_base == NUM_COE, "run did not give exactly 128 writes");
    endtask

    // rotation one cycle after done or load_done closes the join
    task automatic check_rotation(input slot_t from, input slot_t to);
        check_value("o_tpp_mode", 64'(from), 64'(tpp_mode));
        step();
        check_value("o_tpp_mode", 64'(to), 64'(tpp_mode));
        step();
        check_value("o_madd_done", 64'd0, 64'(madd_done));  // new drain slot armed
    endtask

    initial begin
        rst        = 1'b1;
        load_valid = 1'b0;
        load_idx   = '0;
        load_data  = '0;
        load_last  = 1'b0;
        madd_start = 1'b0;
        for (int k = 0; k < NUM_COE; k++) begin
            for (int p = 0; p < NUM_POLY; p++) begin
                psum_mem[coe_idx_t'(k)].poly[p] = (k % 32 == 7) ? TOP_COE : rand_coe();
            end
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // state out of reset
        check_value("o_madd_we", 64'd0, 64'(madd_we));
        check_value("o_madd_done", 64'd1, 64'(madd_done));
        check_value("o_tpp_mode", 64'd0, 64'(tpp_mode));
        pulse_start();  // ignored while the drain is idle
        repeat (5) step();
        check_true(wr_total == 0, "start with done high produced writes");

        // load A while the drain is idle so rotation follows
        load_polyvec(2'd0);
        check_rotation(2'd0, 2'd1);

        // empty drain slot run while B loads
        fork
            run_madd(1'b0, 2'd0, 1'b0);
            begin
                step();
                load_polyvec(2'd1);
                check_value("o_madd_done", 64'd0, 64'(madd_done));
                check_value("o_tpp_mode", 64'd1, 64'(tpp_mode));  // held by the running drain
            end
        join
        check_rotation(2'd1, 2'd2);

        // drain A and hold B while C loads so three polyvecs are in flight
        fork
            run_madd(1'b1, 2'd0, 1'b1);
            begin
                step();
                load_polyvec(2'd2);
                check_value("o_tpp_mode", 64'd2, 64'(tpp_mode));
            end
        join
        check_rotation(2'd2, 2'd0);

        // B comes out after the rotation
        run_madd(1'b1, 2'd1, 1'b0);
        repeat (3) step();
        check_value("o_tpp_mode", 64'd0, 64'(tpp_mode));  // no load pending
        check_value("o_madd_done", 64'd1, 64'(madd_done));
        pulse_start();
        repeat (5) step();
        check_true(wr_total == 3 * NUM_COE, "write total differs from three runs of 128");

        $display("Simulation passed");
        $finish;
    end

endmodule
